/* mem_consts.svh */
// memory subsystem constants, included by the package and by every RTL module

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

////////////////////////////////////////////////////////////
// address and storage
////////////////////////////////////////////////////////////

`define XLEN                  32     // byte address width
`define MEM_SIZE_IN_BYTES     4096
`define MEM_64BIT_LINES       512    // MEM_SIZE_IN_BYTES / 8

////////////////////////////////////////////////////////////
// transaction tags and timing
////////////////////////////////////////////////////////////

// tags run 1..NUM_MEM_TAGS, tag 0 means no transaction
`define NUM_MEM_TAGS          15

`define MEM_LATENCY_IN_CYCLES 4      // edges from acceptance until the load may return

`endif

/* mem_pkg.sv */
// shared types for the memory subsystem RTL and its testbench, imported by wildcard

`include "mem_consts.svh"

package mem_pkg;

	typedef logic [`XLEN-1:0] mem_addr_t;   // byte address
	typedef logic [63:0]      mem_data_t;   // one 64-bit line on the bus
	typedef logic [3:0]       mem_tag_t;    // 0 = none / rejected

	// memory command bus
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	// access width
	typedef enum logic [1:0] {
		BYTE   = 2'h0,
		HALF   = 2'h1,
		WORD   = 2'h2,
		DOUBLE = 2'h3
	} mem_size_e;

	// which requester owns a transaction
	typedef enum logic {
		PORT_FETCH = 1'b0,
		PORT_DATA  = 1'b1
	} port_sel_e;

endpackage

/* tagged_mem.sv */
// tagged pipelined main memory with byte-level access, fixed latency and one load return bus

`timescale 1ns/1ps

`include "mem_consts.svh"

module tagged_mem import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  mem_addr_t mem_addr,
	input  mem_data_t mem_wdata,
	input  mem_size_e mem_size,
	input  bus_cmd_e  mem_command,
	output mem_tag_t  mem_response,   // accepted tag, 0 = rejected
	output mem_tag_t  mem_ret_tag,    // 0 = nothing returned
	output mem_data_t mem_ret_data
);

	localparam int LINE_W = $clog2(`MEM_64BIT_LINES);
	localparam int CNT_W  = $clog2(`MEM_LATENCY_IN_CYCLES + 1);

	mem_data_t        mem_array [`MEM_64BIT_LINES];
	mem_data_t        loaded_data [1:`NUM_MEM_TAGS];
	logic [CNT_W-1:0] cycles_left [1:`NUM_MEM_TAGS];
	logic [`NUM_MEM_TAGS:1] waiting;   // load finished or finishing, needs the bus

	logic [LINE_W-1:0] line_idx;
	logic [2:0]        byte_off;
	mem_data_t         cur_line;
	logic              addr_ok;
	logic              align_ok;
	logic              req_ok;
	logic              accept;
	mem_tag_t          free_tag;
	mem_tag_t          ret_tag;

	logic [7:0]        byte_en;
	mem_data_t         wdata_rep;
	mem_data_t         store_line;
	mem_data_t         shifted;
	mem_data_t         load_value;

	// contents start cleared, reset leaves them alone
	initial begin
		for (int i = 0; i < `MEM_64BIT_LINES; i++) begin
			mem_array[i] = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// request check and tag allocation
	////////////////////////////////////////////////////////////

	assign line_idx = mem_addr[LINE_W+2:3];
	assign byte_off = mem_addr[2:0];
	assign cur_line = mem_array[line_idx];
	assign addr_ok  = (mem_addr < `MEM_SIZE_IN_BYTES);

	always_comb begin
		case (mem_size)
			BYTE:    align_ok = 1'b1;
			HALF:    align_ok = (byte_off[0] == 1'b0);
			WORD:    align_ok = (byte_off[1:0] == 2'b00);
			default: align_ok = (byte_off == 3'b000);
		endcase
	end

	assign req_ok = ((mem_command == BUS_LOAD) || (mem_command == BUS_STORE)) &&
	                addr_ok && align_ok;

	// scan downwards so the lowest free tag is left in free_tag
	always_comb begin
		free_tag = '0;
		for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
			if ((cycles_left[i] == '0) && !waiting[i]) begin
				free_tag = mem_tag_t'(i);
			end
		end
	end

	assign accept = req_ok && (free_tag != '0);

	// a load is ready when its counter hits 0 at this edge or already has
	always_comb begin
		ret_tag = '0;
		for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
			if (waiting[i] && (cycles_left[i] <= CNT_W'(1))) begin
				ret_tag = mem_tag_t'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// subword merge and extract
	////////////////////////////////////////////////////////////

	always_comb begin
		case (mem_size)
			BYTE: begin
				byte_en   = 8'h01 << byte_off;
				wdata_rep = {8{mem_wdata[7:0]}};
			end
			HALF: begin
				byte_en   = 8'h03 << byte_off;
				wdata_rep = {4{mem_wdata[15:0]}};
			end
			WORD: begin
				byte_en   = 8'h0f << byte_off;
				wdata_rep = {2{mem_wdata[31:0]}};
			end
			default: begin
				byte_en   = 8'hff;   // full line
				wdata_rep = mem_wdata;
			end
		endcase
	end

	always_comb begin
		for (int b = 0; b < 8; b++) begin
			store_line[8*b +: 8] = byte_en[b] ? wdata_rep[8*b +: 8] : cur_line[8*b +: 8];
		end
	end

	assign shifted = cur_line >> {byte_off, 3'b000};

	always_comb begin
		case (mem_size)
			BYTE:    load_value = {56'b0, shifted[7:0]};    // zero-extended
			HALF:    load_value = {48'b0, shifted[15:0]};
			WORD:    load_value = {32'b0, shifted[31:0]};
			default: load_value = cur_line;
		endcase
	end

	////////////////////////////////////////////////////////////
	// tag state and registered outputs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
				cycles_left[i] <= '0;
			end
			waiting      <= '0;
			mem_response <= '0;
			mem_ret_tag  <= '0;
		end else begin
			for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
				if (cycles_left[i] != '0) begin
					cycles_left[i] <= cycles_left[i] - CNT_W'(1);
				end
			end
			if (ret_tag != '0) begin
				waiting[ret_tag] <= 1'b0;    // never the same tag as free_tag
			end
			if (accept) begin
				cycles_left[free_tag] <= CNT_W'(`MEM_LATENCY_IN_CYCLES);
				if (mem_command == BUS_LOAD) begin
					waiting[free_tag] <= 1'b1;
				end
			end
			mem_response <= accept ? free_tag : '0;
			mem_ret_tag  <= ret_tag;
		end
	end

	// storage and data path
	always_ff @(posedge clk) begin
		if (accept && (mem_command == BUS_STORE)) begin
			mem_array[line_idx] <= store_line;
		end
		if (accept && (mem_command == BUS_LOAD)) begin
			loaded_data[free_tag] <= load_value;   // read happens at acceptance
		end
		if (ret_tag != '0) begin
			mem_ret_data <= loaded_data[ret_tag];
		end
	end

endmodule

/* mem_req_arbiter.sv */
// fixed-priority arbiter giving the memory command bus to the data or fetch port

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_req_arbiter import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	// fetch port, loads only
	input  mem_addr_t fetch_addr,
	input  bus_cmd_e  fetch_command,
	// data port
	input  mem_addr_t data_addr,
	input  mem_data_t data_wdata,
	input  mem_size_e data_size,
	input  bus_cmd_e  data_command,
	// registered acceptance from the memory
	input  mem_tag_t  mem_response,
	output mem_tag_t  fetch_response,
	output mem_tag_t  data_response,
	// memory command bus
	output mem_addr_t mem_addr,
	output mem_data_t mem_wdata,
	output mem_size_e mem_size,
	output bus_cmd_e  mem_command,
	output port_sel_e resp_owner     // who this cycle's mem_response belongs to
);

	logic      data_sel;
	logic      fetch_load;
	port_sel_e grant_q;

	assign data_sel   = (data_command != BUS_NONE);   // data port always wins
	assign fetch_load = (fetch_command == BUS_LOAD);  // anything else from fetch is dropped

	////////////////////////////////////////////////////////////
	// forward the granted request
	////////////////////////////////////////////////////////////

	always_comb begin
		if (data_sel) begin
			mem_addr    = data_addr;
			mem_size    = data_size;
			mem_command = data_command;
		end else begin
			mem_addr    = fetch_addr;
			mem_size    = DOUBLE;                      // fetch always reads a full line
			mem_command = fetch_load ? BUS_LOAD : BUS_NONE;
		end
	end

	assign mem_wdata = data_wdata;   // only stores use it and only data stores

	// remember the grant for the response cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_q <= PORT_DATA;
		end else begin
			grant_q <= data_sel ? PORT_DATA : PORT_FETCH;
		end
	end

	////////////////////////////////////////////////////////////
	// steer the acceptance tag
	////////////////////////////////////////////////////////////

	assign resp_owner     = grant_q;
	assign fetch_response = (grant_q == PORT_FETCH) ? mem_response : '0;
	assign data_response  = (grant_q == PORT_DATA)  ? mem_response : '0;

endmodule

/* load_tag_router.sv */
// per-tag owner table that sends each returned load to the port that issued it

`timescale 1ns/1ps

`include "mem_consts.svh"

module load_tag_router import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  mem_tag_t  mem_response,   // nonzero = a tag was just handed out
	input  port_sel_e resp_owner,
	input  mem_tag_t  mem_ret_tag,
	input  mem_data_t mem_ret_data,
	output mem_tag_t  fetch_ret_tag,
	output mem_data_t fetch_ret_data,
	output mem_tag_t  data_ret_tag,
	output mem_data_t data_ret_data
);

	port_sel_e owner_tbl [1:`NUM_MEM_TAGS];
	port_sel_e ret_owner;
	logic      ret_valid;
	logic      to_fetch;
	logic      to_data;

	////////////////////////////////////////////////////////////
	// owner table
	////////////////////////////////////////////////////////////

	// store tags get written too, they just never come back
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
				owner_tbl[i] <= PORT_DATA;
			end
		end else if (mem_response != '0) begin
			owner_tbl[mem_response] <= resp_owner;
		end
	end

	////////////////////////////////////////////////////////////
	// return steering
	////////////////////////////////////////////////////////////

	assign ret_valid = (mem_ret_tag != '0);

	always_comb begin
		ret_owner = PORT_DATA;
		if (ret_valid) begin
			ret_owner = owner_tbl[mem_ret_tag];   // tag 0 has no entry
		end
	end

	assign to_fetch = ret_valid && (ret_owner == PORT_FETCH);
	assign to_data  = ret_valid && (ret_owner == PORT_DATA);

	assign fetch_ret_tag  = to_fetch ? mem_ret_tag  : '0;
	assign fetch_ret_data = to_fetch ? mem_ret_data : '0;
	assign data_ret_tag   = to_data  ? mem_ret_tag  : '0;
	assign data_ret_data  = to_data  ? mem_ret_data : '0;

endmodule

/* mem_sys_top.sv */
// memory subsystem top, two requester ports sharing one tagged memory

`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_sys_top import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	// fetch requester, DOUBLE loads only
	input  mem_addr_t fetch_addr,
	input  bus_cmd_e  fetch_command,
	// data requester
	input  mem_addr_t data_addr,
	input  mem_data_t data_wdata,
	input  mem_size_e data_size,
	input  bus_cmd_e  data_command,
	// acceptance, one cycle after the request
	output mem_tag_t  fetch_response,
	output mem_tag_t  data_response,
	// load returns
	output mem_tag_t  fetch_ret_tag,
	output mem_data_t fetch_ret_data,
	output mem_tag_t  data_ret_tag,
	output mem_data_t data_ret_data
);

	////////////////////////////////////////////////////////////
	// internal buses
	////////////////////////////////////////////////////////////

	mem_addr_t mem_addr;
	mem_data_t mem_wdata;
	mem_size_e mem_size;
	bus_cmd_e  mem_command;
	mem_tag_t  mem_response;
	mem_tag_t  mem_ret_tag;
	mem_data_t mem_ret_data;
	port_sel_e resp_owner;

	mem_req_arbiter arb0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.fetch_addr     (fetch_addr),
		.fetch_command  (fetch_command),
		.data_addr      (data_addr),
		.data_wdata     (data_wdata),
		.data_size      (data_size),
		.data_command   (data_command),
		.mem_response   (mem_response),
		.fetch_response (fetch_response),
		.data_response  (data_response),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_size       (mem_size),
		.mem_command    (mem_command),
		.resp_owner     (resp_owner)
	);

	tagged_mem mem0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_size     (mem_size),
		.mem_command  (mem_command),
		.mem_response (mem_response),
		.mem_ret_tag  (mem_ret_tag),
		.mem_ret_data (mem_ret_data)
	);

	// no added cycles, router is combinational on the memory's registered outputs
	load_tag_router rtr0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_response   (mem_response),
		.resp_owner     (resp_owner),
		.mem_ret_tag    (mem_ret_tag),
		.mem_ret_data   (mem_ret_data),
		.fetch_ret_tag  (fetch_ret_tag),
		.fetch_ret_data (fetch_ret_data),
		.data_ret_tag   (data_ret_tag),
		.data_ret_data  (data_ret_data)
	);

endmodule

/* tb_mem_sys.sv */
// self-checking testbench for mem_sys_top, reference model plus concurrent assertions on every output

`timescale 1ns/1ps

`include "mem_consts.svh"

module tb_mem_sys import mem_pkg::*; ();

	localparam int BYTE_AW        = $clog2(`MEM_SIZE_IN_BYTES);
	localparam int TOTAL_REQS     = 2 + 56 + 10 + 40 + 70;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_REQS * (`MEM_LATENCY_IN_CYCLES + 2) + 100;

	logic      clk;
	logic      rst_n;
	mem_addr_t fetch_addr;
	bus_cmd_e  fetch_command;
	mem_addr_t data_addr;
	mem_data_t data_wdata;
	mem_size_e data_size;
	bus_cmd_e  data_command;
	mem_tag_t  fetch_response;
	mem_tag_t  data_response;
	mem_tag_t  fetch_ret_tag;
	mem_data_t fetch_ret_data;
	mem_tag_t  data_ret_tag;
	mem_data_t data_ret_data;

	// reference state
	logic [7:0] shadow [`MEM_SIZE_IN_BYTES];
	logic       busy [1:`NUM_MEM_TAGS];
	logic       is_load [1:`NUM_MEM_TAGS];
	int         acc_edge [1:`NUM_MEM_TAGS];   // edge at which the tag was accepted
	port_sel_e  tag_owner [1:`NUM_MEM_TAGS];
	mem_data_t  tag_val [1:`NUM_MEM_TAGS];    // expected load data
	int         edge_cnt;
	int         cycle_cnt;

	// expected outputs for the current cycle
	mem_tag_t  exp_fetch_resp;
	mem_tag_t  exp_data_resp;
	mem_tag_t  exp_fetch_ret;
	mem_tag_t  exp_data_ret;
	mem_data_t exp_ret_data;
	int        outstanding_q;

	mem_sys_top dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.fetch_addr     (fetch_addr),
		.fetch_command  (fetch_command),
		.data_addr      (data_addr),
		.data_wdata     (data_wdata),
		.data_size      (data_size),
		.data_command   (data_command),
		.fetch_response (fetch_response),
		.data_response  (data_response),
		.fetch_ret_tag  (fetch_ret_tag),
		.fetch_ret_data (fetch_ret_data),
		.data_ret_tag   (data_ret_tag),
		.data_ret_data  (data_ret_data)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// failure reporting and shadow memory helpers
	////////////////////////////////////////////////////////////

	task automatic halt_failed();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	task automatic show_mismatch(input string sig, input mem_data_t exp_v, input mem_data_t act_v);
		$display("[FAIL] t=%0t %s expected %h actual %h", $time, sig, exp_v, act_v);
		halt_failed();
	endtask

	task automatic explain_failure(input string what);
		$display("ERROR t=%0t %s", $time, what);
		halt_failed();
	endtask

	function automatic int size_bytes(input mem_size_e s);
		case (s)
			BYTE:    return 1;
			HALF:    return 2;
			WORD:    return 4;
			default: return 8;
		endcase
	endfunction

	function automatic logic is_aligned(input mem_addr_t a, input mem_size_e s);
		return (a & mem_addr_t'(size_bytes(s) - 1)) == '0;
	endfunction

	// little-endian bytes, zero-extended
	function automatic mem_data_t shadow_load(input mem_addr_t a, input mem_size_e s);
		mem_data_t          v;
		logic [BYTE_AW-1:0] idx;
		v = '0;
		for (int i = 0; i < size_bytes(s); i++) begin
			idx = a[BYTE_AW-1:0] + BYTE_AW'(i);
			v[8*i +: 8] = shadow[idx];
		end
		return v;
	endfunction

	task automatic shadow_store(input mem_addr_t a, input mem_size_e s, input mem_data_t d);
		logic [BYTE_AW-1:0] idx;
		for (int i = 0; i < size_bytes(s); i++) begin
			idx = a[BYTE_AW-1:0] + BYTE_AW'(i);
			shadow[idx] = d[8*i +: 8];
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model, runs on the same edge the DUT samples
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin : ref_model
		port_sel_e req_owner;
		bus_cmd_e  req_cmd;
		mem_addr_t req_addr;
		mem_size_e req_size;
		logic      req_ok;
		mem_tag_t  free_t;
		mem_tag_t  ret_t;
		mem_tag_t  acc_t;
		int        n_out;
		if (!rst_n) begin
			for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin
				busy[t] = 1'b0;
			end
			exp_fetch_resp <= '0;
			exp_data_resp  <= '0;
			exp_fetch_ret  <= '0;
			exp_data_ret   <= '0;
			outstanding_q  <= 0;
		end else begin
			if (data_command != BUS_NONE) begin   // data port has priority
				req_owner = PORT_DATA;
				req_cmd   = data_command;
				req_addr  = data_addr;
				req_size  = data_size;
			end else begin
				req_owner = PORT_FETCH;
				req_cmd   = (fetch_command == BUS_LOAD) ? BUS_LOAD : BUS_NONE;
				req_addr  = fetch_addr;
				req_size  = DOUBLE;
			end
			req_ok = ((req_cmd == BUS_LOAD) || (req_cmd == BUS_STORE)) &&
			         (req_addr < `MEM_SIZE_IN_BYTES) && is_aligned(req_addr, req_size);

			// stores free their tag after the latency, loads once returned
			free_t = '0;
			ret_t  = '0;
			for (int t = `NUM_MEM_TAGS; t >= 1; t--) begin
				if (busy[t] && !is_load[t] &&
				    (edge_cnt >= acc_edge[t] + `MEM_LATENCY_IN_CYCLES + 1)) begin
					busy[t] = 1'b0;
				end
				if (!busy[t]) begin
					free_t = mem_tag_t'(t);
				end
				if (busy[t] && is_load[t] &&
				    (edge_cnt >= acc_edge[t] + `MEM_LATENCY_IN_CYCLES)) begin
					ret_t = mem_tag_t'(t);   // lowest ready tag wins the bus
				end
			end

			acc_t = req_ok ? free_t : '0;
			if (acc_t != '0) begin
				busy[acc_t]      = 1'b1;
				is_load[acc_t]   = (req_cmd == BUS_LOAD);
				acc_edge[acc_t]  = edge_cnt;
				tag_owner[acc_t] = req_owner;
				if (req_cmd == BUS_LOAD) begin
					tag_val[acc_t] = shadow_load(req_addr, req_size);
				end else begin
					shadow_store(req_addr, req_size, data_wdata);
				end
			end
			exp_fetch_resp <= (req_owner == PORT_FETCH) ? acc_t : '0;
			exp_data_resp  <= (req_owner == PORT_DATA) ? acc_t : '0;

			if (ret_t != '0) begin
				exp_fetch_ret <= (tag_owner[ret_t] == PORT_FETCH) ? ret_t : '0;
				exp_data_ret  <= (tag_owner[ret_t] == PORT_DATA) ? ret_t : '0;
				exp_ret_data  <= tag_val[ret_t];
				busy[ret_t] = 1'b0;
			end else begin
				exp_fetch_ret <= '0;
				exp_data_ret  <= '0;
			end

			n_out = 0;
			for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin
				if (busy[t] && is_load[t]) begin
					n_out++;
				end
			end
			outstanding_q <= n_out;
		end
		edge_cnt = edge_cnt + 1;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			explain_failure("cycle limit reached, a load never returned or the run stalled");
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rst_n) fetch_response === exp_fetch_resp)
		else show_mismatch("fetch_response", 64'($sampled(exp_fetch_resp)),
			64'($sampled(fetch_response)));
	assert property (@(posedge clk) disable iff (!rst_n) data_response === exp_data_resp)
		else show_mismatch("data_response", 64'($sampled(exp_data_resp)),
			64'($sampled(data_response)));
	assert property (@(posedge clk) disable iff (!rst_n) fetch_ret_tag === exp_fetch_ret)
		else show_mismatch("fetch_ret_tag", 64'($sampled(exp_fetch_ret)),
			64'($sampled(fetch_ret_tag)));
	assert property (@(posedge clk) disable iff (!rst_n) data_ret_tag === exp_data_ret)
		else show_mismatch("data_ret_tag", 64'($sampled(exp_data_ret)),
			64'($sampled(data_ret_tag)));
	assert property (@(posedge clk) disable iff (!rst_n)
		(exp_fetch_ret == '0) || (fetch_ret_data === exp_ret_data))
		else show_mismatch("fetch_ret_data", $sampled(exp_ret_data), $sampled(fetch_ret_data));
	assert property (@(posedge clk) disable iff (!rst_n)
		(exp_data_ret == '0) || (data_ret_data === exp_ret_data))
		else show_mismatch("data_ret_data", $sampled(exp_ret_data), $sampled(data_ret_data));

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic present(input bus_cmd_e f_cmd, input mem_addr_t f_addr, input bus_cmd_e d_cmd,
		input mem_addr_t d_addr, input mem_size_e d_size, input mem_data_t d_wdata);
		@(posedge clk);
		fetch_command <= f_cmd;
		fetch_addr    <= f_addr;
		data_command  <= d_cmd;
		data_addr     <= d_addr;
		data_size     <= d_size;
		data_wdata    <= d_wdata;
	endtask

	task automatic data_req(input bus_cmd_e c, input mem_addr_t a, input mem_size_e s,
		input mem_data_t d);
		present(BUS_NONE, '0, c, a, s, d);
	endtask

	task automatic idle();
		present(BUS_NONE, '0, BUS_NONE, '0, BYTE, '0);
	endtask

	// wait until every accepted load has come back
	task automatic drain();
		idle();
		idle();
		while (outstanding_q != 0) begin
			idle();
		end
		idle();   // the last return gets compared at this edge
	endtask

	function automatic mem_addr_t rand_addr(input mem_size_e s);
		return mem_addr_t'($urandom % 512) & ~mem_addr_t'(size_bytes(s) - 1);
	endfunction

	initial begin : stimulus
		mem_addr_t a;
		mem_size_e s;
		bus_cmd_e  c;
		void'($urandom(32'h2bfa_f4b6));
		clk           = 1'b0;
		rst_n         = 1'b0;
		fetch_addr    = '0;
		fetch_command = BUS_NONE;
		data_addr     = '0;
		data_wdata    = '0;
		data_size     = BYTE;
		data_command  = BUS_NONE;
		edge_cnt      = 0;
		cycle_cnt     = 0;
		for (int i = 0; i < `MEM_SIZE_IN_BYTES; i++) begin
			shadow[i] = 8'h00;   // memory starts cleared
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) idle();

		// one store then one load, no contention
		data_req(BUS_STORE, 32'h40, DOUBLE, 64'h0123_4567_89ab_cdef);
		data_req(BUS_LOAD, 32'h40, DOUBLE, '0);
		drain();

		// subword stores, loads of every size
		for (int i = 0; i < 24; i++) begin
			s = mem_size_e'(2'($urandom % 3));
			data_req(BUS_STORE, rand_addr(s), s, {$urandom, $urandom});
		end
		for (int i = 0; i < 32; i++) begin
			s = mem_size_e'(2'($urandom % 4));
			data_req(BUS_LOAD, rand_addr(s), s, '0);
		end
		drain();

		// misaligned and out of range, then look at the lines
		data_req(BUS_STORE, 32'h81, HALF, 64'hffff);
		data_req(BUS_STORE, 32'h86, WORD, 64'hffff_ffff);
		data_req(BUS_LOAD, 32'h8c, DOUBLE, '0);
		data_req(BUS_STORE, 32'h1000, BYTE, 64'hff);
		data_req(BUS_STORE, 32'hffff_fff8, DOUBLE, '1);
		data_req(BUS_LOAD, 32'h2000, WORD, '0);
		data_req(BUS_LOAD, 32'h80, DOUBLE, '0);
		data_req(BUS_LOAD, 32'h88, DOUBLE, '0);
		data_req(BUS_LOAD, 32'h000, DOUBLE, '0);
		data_req(BUS_LOAD, 32'hff8, DOUBLE, '0);
		drain();

		// back-to-back loads
		for (int i = 0; i < 40; i++) begin
			s = mem_size_e'(2'($urandom % 4));
			data_req(BUS_LOAD, rand_addr(s), s, '0);
		end
		drain();

		// both ports at once, then fetch alone
		for (int i = 0; i < 30; i++) begin
			s = mem_size_e'(2'($urandom % 4));
			a = rand_addr(s);
			case ($urandom % 3)
				0:       c = BUS_NONE;
				1:       c = BUS_LOAD;
				default: c = BUS_STORE;
			endcase
			present(BUS_LOAD, rand_addr(DOUBLE), c, a, s, {$urandom, $urandom});
		end
		for (int i = 0; i < 10; i++) begin
			present(BUS_LOAD, rand_addr(DOUBLE), BUS_NONE, '0, BYTE, '0);
		end
		drain();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
mem_pkg.sv
tagged_mem.sv
mem_req_arbiter.sv
load_tag_router.sv
mem_sys_top.sv
tb_mem_sys.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mem_sys
RTL_TOP   := mem_sys_top
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_STR  := TEST RESULT: PASS

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) +incdir+. mem_pkg.sv tagged_mem.sv \
		mem_req_arbiter.sv load_tag_router.sv mem_sys_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
